// ==== Bender.yml ====
package:
  name: prng

sources:
  - include_dirs:
      - include
    files:
      - rtl/cipherPkg.sv
      - rtl/streamPkg.sv
      - rtl/aesCore.sv
      - rtl/keystreamGen.sv
      - rtl/blockBuffer.sv
      - rtl/randFunnel.sv
      - rtl/prng.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/prng_assertions.sv
      - tb/prng_tb.sv

// ==== include/prng_macros.svh ====
/*
 * Build-time constants of the AES counter-mode PRNG: widths, buffer depth,
 * round count and the fixed cipher key
 */
`ifndef PRNG_MACROS_SVH
`define PRNG_MACROS_SVH

// Width of one word on the random output port
`define RAND_WIDTH 32

// AES-128 block and key width, and its round count
`define AES_WIDTH 128
`define AES_ROUNDS 10

// Number of finished blocks the block buffer can hold
`define BUFFER_DEPTH 2

`define WORDS_PER_BLOCK (`AES_WIDTH / `RAND_WIDTH)

// Fixed key; the sequence depends only on this and the block count
`define AES_KEY 128'hd840_e1a8_dcca_e7ec_d91f_6148_7af2_cb73

`endif

// ==== rtl/aesCore.sv ====
/*
 * Iterative AES-128 encryption core. One round per clock after a load
 * cycle, with the round key derived on the fly from the fixed key
 */
`timescale 1ns/1ps
`include "prng_macros.svh"

module aesCore (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 start,
    input  cipherPkg::aesBlock_t plain,
    output logic                 busy,
    output cipherPkg::aesBlock_t result,
    output logic                 done
);

    import cipherPkg::*;

    localparam aesBlock_t aesKey = `AES_KEY;
    localparam roundIdx_t lastRound = roundIdx_t'(`AES_ROUNDS);

    aesBlock_t state;
    aesBlock_t roundKey;
    aesBlock_t afterShift;
    aesBlock_t roundOut;
    roundIdx_t round;
    logic      load;

    assign load = start && !busy;

    // ==================================================
    // Round datapath
    // ==================================================

    assign afterShift = shiftRows(subBytes(state));

    // The last round skips the column mix
    always_comb begin
        if (round == lastRound) begin
            roundOut = afterShift ^ roundKey;
        end else begin
            roundOut = mixColumns(afterShift) ^ roundKey;
        end
    end

    // roundKey always holds the key of the round about to run
    always_ff @(posedge Clock) begin
        if (load) begin
            state <= plain ^ aesKey;
            roundKey <= nextRoundKey(aesKey, roundIdx_t'(1));
        end else if (busy) begin
            state <= roundOut;
            roundKey <= nextRoundKey(roundKey, round + 1'b1);
        end
    end

    // The ciphertext stays in the state register until the next load
    assign result = state;

    // ==================================================
    // Round sequencing
    // ==================================================

    always_ff @(posedge Clock) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            round <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                round <= roundIdx_t'(1);
            end else if (busy) begin
                round <= round + 1'b1;
                if (round == lastRound) begin
                    // Result is in the state register from the next cycle on
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/blockBuffer.sv ====
/*
 * Small register FIFO between the cipher and the output funnel.
 * The payload type is a parameter; the writer never overruns it
 */
`timescale 1ns/1ps
`include "prng_macros.svh"

module blockBuffer #(
    parameter type payload_t = logic
) (
    input  logic     Clock,
    input  logic     rst,
    input  payload_t inData,
    input  logic     inValid,
    output payload_t outData,
    output logic     outValid,
    input  logic     outReady
);

    import streamPkg::*;

    localparam int PtrWidth = (`BUFFER_DEPTH > 1) ? $clog2(`BUFFER_DEPTH) : 1;
    localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(`BUFFER_DEPTH - 1);

    payload_t            mem [`BUFFER_DEPTH];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    credit_t             count;
    logic                rdEn;

    assign rdEn = outValid && outReady;
    assign outValid = (count != '0);
    assign outData = mem[rdPtr];

    always_ff @(posedge Clock) begin
        if (inValid) begin
            mem[wrPtr] <= inData;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (inValid) begin
                wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
            end
            count <= count + credit_t'(inValid) - credit_t'(rdEn);
        end
    end

endmodule

// ==== rtl/cipherPkg.sv ====
/*
 * AES-128 types and round functions used by the iterative encryption core.
 * The S-box is computed from the GF(2^8) inverse and the affine map
 */
`include "prng_macros.svh"

package cipherPkg;

    typedef logic [`AES_WIDTH-1:0] aesBlock_t;
    typedef logic [3:0] roundIdx_t;

    // ==================================================
    // GF(2^8) arithmetic
    // ==================================================

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] prod;
        logic [7:0] acc;
        prod = 8'h00;
        acc = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ acc;
            end
            acc = xtime(acc);
        end
        return prod;
    endfunction

    // Inverse is b^254, built from the squares b^2 .. b^128
    function automatic logic [7:0] subByte(input logic [7:0] b);
        logic [7:0] inv;
        logic [7:0] sq;
        logic [7:0] res;
        inv = 8'h01;
        sq = b;
        for (int i = 1; i < 8; i++) begin
            sq = gfMul(sq, sq);
            inv = gfMul(inv, sq);
        end
        for (int i = 0; i < 8; i++) begin
            res[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                     ^ inv[(i + 7) % 8];
        end
        return res ^ 8'h63;
    endfunction

    // ==================================================
    // Round transforms
    // ==================================================

    // Byte i of a block sits at bits [127-8i -: 8]; byte 4c+r is row r of column c
    function automatic aesBlock_t subBytes(input aesBlock_t blk);
        aesBlock_t res;
        for (int i = 0; i < 16; i++) begin
            res[127 - 8 * i -: 8] = subByte(blk[127 - 8 * i -: 8]);
        end
        return res;
    endfunction

    function automatic aesBlock_t shiftRows(input aesBlock_t blk);
        aesBlock_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[127 - 8 * (4 * c + r) -: 8] = blk[127 - 8 * (4 * ((c + r) % 4) + r) -: 8];
            end
        end
        return res;
    endfunction

    function automatic aesBlock_t mixColumns(input aesBlock_t blk);
        aesBlock_t res;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++) begin
            a0 = blk[127 - 32 * c -: 8];
            a1 = blk[119 - 32 * c -: 8];
            a2 = blk[111 - 32 * c -: 8];
            a3 = blk[103 - 32 * c -: 8];
            res[127 - 32 * c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            res[119 - 32 * c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            res[111 - 32 * c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            res[103 - 32 * c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return res;
    endfunction

    // ==================================================
    // Key schedule
    // ==================================================

    // Rcon for rounds 1 to 10 is 01, 02, 04 ... 80, 1b, 36
    function automatic logic [7:0] roundConst(input roundIdx_t round);
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 1; i < 16; i++) begin
            if (i < round) begin
                rc = xtime(rc);
            end
        end
        return rc;
    endfunction

    // Derives the key of the given round from the key of the round before
    function automatic aesBlock_t nextRoundKey(input aesBlock_t key, input roundIdx_t round);
        logic [31:0] temp;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        temp = {key[23:0], key[31:24]};
        temp = {subByte(temp[31:24]), subByte(temp[23:16]),
                subByte(temp[15:8]), subByte(temp[7:0])};
        temp[31:24] = temp[31:24] ^ roundConst(round);
        w0 = key[127:96] ^ temp;
        w1 = key[95:64] ^ w0;
        w2 = key[63:32] ^ w1;
        w3 = key[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

// ==== rtl/keystreamGen.sv ====
/*
 * Seed counter and issue control for the AES counter-mode keystream.
 * Credits make sure every block in flight has a buffer slot waiting
 */
`timescale 1ns/1ps
`include "prng_macros.svh"

module keystreamGen (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 slotFreed,
    output cipherPkg::aesBlock_t block,
    output logic                 blockValid
);

    import cipherPkg::*;
    import streamPkg::*;

    aesBlock_t seed;
    credit_t   credit;
    logic      busy;
    logic      issue;

    // Only one block is in the core at a time, so wait for it to go idle
    assign issue = (credit != '0) && !busy;

    always_ff @(posedge Clock) begin
        if (rst) begin
            seed <= '0;
            credit <= credit_t'(`BUFFER_DEPTH);
        end else begin
            if (issue) begin
                seed <= seed + 1'b1;
            end
            // Issue and a freed slot in the same cycle cancel out
            credit <= credit - credit_t'(issue) + credit_t'(slotFreed);
        end
    end

    aesCore cipher (
        .Clock  (Clock),
        .rst    (rst),
        .start  (issue),
        .plain  (seed),
        .busy   (busy),
        .result (block),
        .done   (blockValid)
    );

endmodule

// ==== rtl/prng.sv ====
/*
 * Pseudo-random number generator built on AES-128 in counter mode.
 * Meant for low-bandwidth uses such as leaf generation, not for secrecy
 */
`timescale 1ns/1ps

module prng (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 randReady,
    output streamPkg::randBeat_t randOut
);

    import cipherPkg::*;

    aesBlock_t block;
    logic      blockValid;
    aesBlock_t bufData;
    logic      bufValid;
    logic      bufReady;
    logic      slotFreed;

    // ==================================================
    // Cipher side
    // ==================================================

    // A slot frees when the funnel takes a block from the buffer
    assign slotFreed = bufValid && bufReady;

    keystreamGen generator (
        .Clock      (Clock),
        .rst        (rst),
        .slotFreed  (slotFreed),
        .block      (block),
        .blockValid (blockValid)
    );

    blockBuffer #(
        .payload_t (aesBlock_t)
    ) outBuffer (
        .Clock    (Clock),
        .rst      (rst),
        .inData   (block),
        .inValid  (blockValid),
        .outData  (bufData),
        .outValid (bufValid),
        .outReady (bufReady)
    );

    // ==================================================
    // Output side
    // ==================================================

    randFunnel funnel (
        .Clock     (Clock),
        .rst       (rst),
        .inData    (bufData),
        .inValid   (bufValid),
        .inReady   (bufReady),
        .randReady (randReady),
        .randOut   (randOut)
    );

endmodule

// ==== rtl/randFunnel.sv ====
/*
 * Width funnel: hands out each 128-bit block as four 32-bit words,
 * lowest word first, over a ready/valid port
 */
`timescale 1ns/1ps
`include "prng_macros.svh"

module randFunnel (
    input  logic                 Clock,
    input  logic                 rst,
    input  cipherPkg::aesBlock_t inData,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic                 randReady,
    output streamPkg::randBeat_t randOut
);

    import cipherPkg::*;
    import streamPkg::*;

    localparam int IdxWidth = $clog2(`WORDS_PER_BLOCK);
    localparam logic [IdxWidth-1:0] LastWord = IdxWidth'(`WORDS_PER_BLOCK - 1);

    aesBlock_t           shiftReg;
    logic [IdxWidth-1:0] wordIdx;
    logic                full;
    logic                take;
    logic                load;

    assign take = full && randReady;
    // Reload in the same cycle the last word leaves, so no bubble
    assign inReady = !full || (take && (wordIdx == LastWord));
    assign load = inReady && inValid;

    assign randOut = '{valid: full, data: randWord_t'(shiftReg[`RAND_WIDTH-1:0])};

    always_ff @(posedge Clock) begin
        if (load) begin
            shiftReg <= inData;
        end else if (take) begin
            shiftReg <= shiftReg >> `RAND_WIDTH;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            full <= 1'b0;
            wordIdx <= '0;
        end else if (load) begin
            full <= 1'b1;
            wordIdx <= '0;
        end else if (take) begin
            wordIdx <= wordIdx + 1'b1;
            if (wordIdx == LastWord) begin
                full <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/streamPkg.sv ====
/*
 * Types of the random output stream and of the buffer occupancy and
 * credit counters
 */
`include "prng_macros.svh"

package streamPkg;

    // One word as handed out on the random port
    typedef logic [`RAND_WIDTH-1:0] randWord_t;

    // Output beat; data is only meaningful while valid is high
    typedef struct packed {
        logic      valid;
        randWord_t data;
    } randBeat_t;

    // Counts buffer entries or free slots, 0 up to one past BUFFER_DEPTH
    typedef logic [$clog2(`BUFFER_DEPTH + 2)-1:0] credit_t;

endpackage

// ==== tb/prng_assertions.sv ====
/*
 * Protocol checks on the random output port of the PRNG top level
 */
`timescale 1ns/1ps

module prngAssertions (
    input logic                 Clock,
    input logic                 rst,
    input logic                 randReady,
    input streamPkg::randBeat_t randOut
);

    // Number of assertion failures so far
    int failures = 0;

    // A stalled word keeps valid up until it is taken
    validHeld: assert property (@(posedge Clock) disable iff (rst)
        randOut.valid && !randReady |=> randOut.valid)
        else begin
            failures = failures + 1;
            $error("randOut.valid dropped before its transfer");
        end

    dataStable: assert property (@(posedge Clock) disable iff (rst)
        randOut.valid && !randReady |=> $stable(randOut.data))
        else begin
            failures = failures + 1;
            $error("randOut.data changed while the word was stalled");
        end

    dataKnown: assert property (@(posedge Clock) disable iff (rst)
        randOut.valid |-> !$isunknown(randOut.data))
        else begin
            failures = failures + 1;
            $error("randOut.data holds X or Z while valid");
        end

    // No word may be offered in the cycle right after a reset edge
    idleAfterReset: assert property (@(posedge Clock)
        rst |=> !randOut.valid)
        else begin
            failures = failures + 1;
            $error("randOut.valid high in the cycle after reset");
        end

endmodule

bind prng prngAssertions protocolChecks (
    .Clock     (Clock),
    .rst       (rst),
    .randReady (randReady),
    .randOut   (randOut)
);

// ==== tb/prng_tb.sv ====
/*
 * Testbench of the AES counter-mode PRNG. Compares every accepted word
 * with an independent AES-128 model under several ready patterns and a reset
 */
`timescale 1ns/1ps
`include "prng_macros.svh"

module prng_tb;

    import streamPkg::*;

    localparam int WordTotal = 4 + 160 + 120 + 8 + 6 + 8;
    localparam int WorstStall = 4;
    localparam int CycleLimit = WordTotal * 4 * WorstStall + 200;

    // AES S-box with entry 0 in the top byte
    localparam logic [2047:0] SboxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    logic      Clock = 1'b0;
    logic      rst;
    logic      randReady;
    randBeat_t randOut;

    int          seed;
    logic [31:0] rnd;
    int          expIdx = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    prng DUT (
        .Clock     (Clock),
        .rst       (rst),
        .randReady (randReady),
        .randOut   (randOut)
    );

    always #50 Clock = ~Clock;

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic [7:0] sboxByte(input logic [7:0] b);
        return SboxTable[2047 - 8 * int'(b) -: 8];
    endfunction

    function automatic logic [7:0] mulTwo(input logic [7:0] b);
        return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // State byte i is row i%4 of column i/4 as in FIPS-197
    function automatic logic [127:0] aesRef(input logic [127:0] key, input logic [127:0] pt);
        logic [31:0]  w [44];
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [31:0]  tmp;
        logic [7:0]   rc;
        logic [7:0]   mix;
        logic [127:0] ct;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32 * i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            tmp = w[i - 1];
            if (i % 4 == 0) begin
                tmp = {sboxByte(tmp[23:16]), sboxByte(tmp[15:8]), sboxByte(tmp[7:0]),
                       sboxByte(tmp[31:24])};
                tmp[31:24] = tmp[31:24] ^ rc;
                rc = mulTwo(rc);
            end
            w[i] = w[i - 4] ^ tmp;
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
        end
        for (int r = 1; r <= 10; r++) begin
            // Substitution and row rotation in one pass
            for (int c = 0; c < 4; c++) begin
                for (int j = 0; j < 4; j++) begin
                    t[4 * c + j] = sboxByte(s[4 * ((c + j) % 4) + j]);
                end
            end
            for (int c = 0; c < 4; c++) begin
                mix = t[4 * c] ^ t[4 * c + 1] ^ t[4 * c + 2] ^ t[4 * c + 3];
                for (int j = 0; j < 4; j++) begin
                    if (r < 10) begin
                        s[4 * c + j] = t[4 * c + j] ^ mix
                                       ^ mulTwo(t[4 * c + j] ^ t[4 * c + (j + 1) % 4]);
                    end else begin
                        s[4 * c + j] = t[4 * c + j];
                    end
                    s[4 * c + j] = s[4 * c + j] ^ w[4 * r + c][31 - 8 * j -: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            ct[127 - 8 * i -: 8] = s[i];
        end
        return ct;
    endfunction

    // Word idx is slice idx%4 of block idx/4 with the lowest slice first
    function automatic logic [31:0] expectedWord(input int idx);
        logic [127:0] blk;
        blk = aesRef(`AES_KEY, 128'(idx / 4));
        return blk[32 * (idx % 4) +: 32];
    endfunction

    // ==================================================
    // Checking
    // ==================================================

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %0h expected %0h", name, got, exp);
        end
    endtask

    always @(posedge Clock) begin
        if (rst) begin
            expIdx = 0;
        end else if (randOut.valid && randReady) begin
            checkValue("randOut.data", randOut.data, expectedWord(expIdx));
            expIdx = expIdx + 1;
        end
    end

    always @(posedge Clock) begin
        cycles = cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, the random output stopped arriving", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Called on a falling edge with rst already high
    task automatic applyReset();
        repeat (3) @(negedge Clock);
        rst = 1'b0;
        checkValue("randOut.valid", randOut.valid, 1'b0);
    endtask

    task automatic waitForWords(input int n);
        int target;
        target = expIdx + n;
        wait (expIdx >= target);
        @(negedge Clock);
    endtask

    task automatic firstBlock();
        applyReset();
        randReady = 1'b1;
        waitForWords(4);
    endtask

    task automatic randomReadyStream(input int blocks);
        int target;
        target = expIdx + 4 * blocks;
        while (expIdx < target) begin
            @(negedge Clock);
            rnd = $random(seed);
            randReady = rnd[0];
        end
        randReady = 1'b1;
    endtask

    // A full buffer keeps the word on offer while credit blocks new seeds
    task automatic longStall();
        randReady = 1'b0;
        repeat (100) @(negedge Clock);
        checkValue("randOut.valid", randOut.valid, 1'b1);
        randReady = 1'b1;
        waitForWords(8);
    endtask

    task automatic midStreamReset();
        waitForWords(6);
        rst = 1'b1;
        applyReset();
        waitForWords(8);
    endtask

    initial begin
        rst = 1'b1;
        randReady = 1'b0;
        seed = 63;
        // FIPS-197 appendix C.1 vector
        checkValue("aesRef", aesRef(128'h000102030405060708090a0b0c0d0e0f,
                                    128'h00112233445566778899aabbccddeeff),
                   128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        firstBlock();
        waitForWords(160);
        randomReadyStream(30);
        longStall();
        midStreamReset();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 DUT.protocolChecks.failures);
        if (errors == 0 && DUT.protocolChecks.failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/cipherPkg.sv
rtl/streamPkg.sv
rtl/aesCore.sv
rtl/keystreamGen.sv
rtl/blockBuffer.sv
rtl/randFunnel.sv
rtl/prng.sv
tb/prng_assertions.sv
tb/prng_tb.sv
